/* logic/bus_pkg.sv */
package bus_pkg;

  localparam int addr_w = 32;
  localparam int data_w = 32;
  localparam int strb_w = 4;
  localparam int size_w = 3;

  typedef logic [1:0] resp_t;

  localparam resp_t resp_okay   = 2'd0;
  localparam resp_t resp_slverr = 2'd2;

  // 32-bit access, used for every fetch
  localparam logic [size_w-1:0] size_word = 3'd2;

  // mtime word addresses
  localparam logic [addr_w-1:0] clint_mtime_lo = 32'h0200_0048;
  localparam logic [addr_w-1:0] clint_mtime_hi = 32'h0200_004c;

  typedef enum logic [1:0] {
    own_none,
    own_fetch,
    own_lsu
  } grant_t;

endpackage

/* logic/axi_rd_if.sv */
interface axi_rd_if;
  import bus_pkg::*;

  logic [addr_w-1:0] araddr;
  logic              arvalid;
  logic              arready;

  logic [data_w-1:0] rdata;
  resp_t             rresp;
  logic              rvalid;
  logic              rready;

  modport mst (
    output araddr,
    output arvalid,
    input  arready,
    input  rdata,
    input  rresp,
    input  rvalid,
    output rready
  );

  modport slv (
    input  araddr,
    input  arvalid,
    output arready,
    output rdata,
    output rresp,
    output rvalid,
    input  rready
  );

endinterface

/* logic/clint_timer.sv */
module clint_timer (
  input  logic  clock,
  input  logic  arst_n,
  axi_rd_if.slv rd
);
  import bus_pkg::*;

  logic [63:0]       mtime_q;
  logic              rvalid_q;
  logic [data_w-1:0] rdata_q;
  resp_t             rresp_q;
  logic              ar_hs;

  assign ar_hs = rd.arvalid && rd.arready;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      mtime_q <= '0;
    end else begin
      mtime_q <= mtime_q + 64'd1; // free running
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      rvalid_q <= 1'b0;
    end else if (ar_hs) begin
      rvalid_q <= 1'b1;
    end else if (rd.rready) begin
      rvalid_q <= 1'b0;
    end
  end

  // sample the selected word at the address handshake
  always_ff @(posedge clock) begin
    if (ar_hs) begin
      if (rd.araddr == clint_mtime_lo) begin
        rdata_q <= mtime_q[31:0];
        rresp_q <= resp_okay;
      end else if (rd.araddr == clint_mtime_hi) begin
        rdata_q <= mtime_q[63:32];
        rresp_q <= resp_okay;
      end else begin
        rdata_q <= '0;
        rresp_q <= resp_slverr; // unmapped
      end
    end
  end

  assign rd.arready = !rvalid_q;
  assign rd.rvalid  = rvalid_q;
  assign rd.rdata   = rdata_q;
  assign rd.rresp   = rresp_q;

endmodule

/* logic/bus_arbiter.sv */
module bus_arbiter (
  input  logic                        clock,
  input  logic                        arst_n,

  input  logic [bus_pkg::addr_w-1:0] fetch_araddr,
  input  logic                        fetch_arvalid,
  output logic                        fetch_arready,
  input  logic                        fetch_rready,
  output logic [bus_pkg::data_w-1:0] fetch_rdata,
  output bus_pkg::resp_t              fetch_rresp,
  output logic                        fetch_rvalid,

  input  logic [bus_pkg::addr_w-1:0] lsu_araddr,
  input  logic [bus_pkg::size_w-1:0] lsu_arsize,
  input  logic                        lsu_arvalid,
  output logic                        lsu_arready,
  input  logic                        lsu_rready,
  output logic [bus_pkg::data_w-1:0] lsu_rdata,
  output bus_pkg::resp_t              lsu_rresp,
  output logic                        lsu_rvalid,

  input  logic [bus_pkg::addr_w-1:0] lsu_awaddr,
  input  logic [bus_pkg::size_w-1:0] lsu_awsize,
  input  logic                        lsu_awvalid,
  output logic                        lsu_awready,
  input  logic [bus_pkg::data_w-1:0] lsu_wdata,
  input  logic [bus_pkg::strb_w-1:0] lsu_wstrb,
  input  logic                        lsu_wvalid,
  output logic                        lsu_wready,
  input  logic                        lsu_bready,
  output bus_pkg::resp_t              lsu_bresp,
  output logic                        lsu_bvalid,

  output logic [bus_pkg::addr_w-1:0] m_araddr,
  output logic [bus_pkg::size_w-1:0] m_arsize,
  output logic                        m_arvalid,
  input  logic                        m_arready,
  input  logic [bus_pkg::data_w-1:0] m_rdata,
  input  bus_pkg::resp_t              m_rresp,
  input  logic                        m_rvalid,
  output logic                        m_rready,
  output logic [bus_pkg::addr_w-1:0] m_awaddr,
  output logic [bus_pkg::size_w-1:0] m_awsize,
  output logic                        m_awvalid,
  input  logic                        m_awready,
  output logic [bus_pkg::data_w-1:0] m_wdata,
  output logic [bus_pkg::strb_w-1:0] m_wstrb,
  output logic                        m_wvalid,
  input  logic                        m_wready,
  input  bus_pkg::resp_t              m_bresp,
  input  logic                        m_bvalid,
  output logic                        m_bready,

  axi_rd_if.mst                       clint_rd
);
  import bus_pkg::*;

  grant_t grant_q;
  grant_t winner;
  grant_t ar_sel_q;
  logic   ar_lock_q;
  logic   clint_pend_q;
  logic   is_clint;
  logic   ar_free;
  logic   fetch_sel;
  logic   lsu_sel;

  assign is_clint = (lsu_araddr == clint_mtime_lo) || (lsu_araddr == clint_mtime_hi);
  assign ar_free  = (grant_q == own_none);

  // keep a stalled request on the same master until it is accepted
  assign winner    = ar_lock_q ? ar_sel_q : (fetch_arvalid ? own_fetch : own_lsu);
  assign fetch_sel = ar_free && (winner == own_fetch) && fetch_arvalid;
  assign lsu_sel   = ar_free && (winner == own_lsu) && lsu_arvalid && !is_clint;

  assign m_arvalid = fetch_sel || lsu_sel;
  assign m_araddr  = (winner == own_fetch) ? fetch_araddr : lsu_araddr;
  assign m_arsize  = (winner == own_fetch) ? size_word : lsu_arsize;

  assign fetch_arready = fetch_sel && m_arready;
  assign lsu_arready   = is_clint ? clint_rd.arready : (lsu_sel && m_arready);

  assign clint_rd.araddr  = lsu_araddr;
  assign clint_rd.arvalid = lsu_arvalid && is_clint;
  assign clint_rd.rready  = clint_pend_q && lsu_rready;

  // responses follow the owner, not the current address
  assign m_rready = (grant_q == own_fetch) ? fetch_rready :
                    (grant_q == own_lsu)   ? lsu_rready   : 1'b0;

  assign fetch_rvalid = (grant_q == own_fetch) && m_rvalid;
  assign fetch_rdata  = m_rdata;
  assign fetch_rresp  = m_rresp;

  assign lsu_rvalid = clint_pend_q ? clint_rd.rvalid : ((grant_q == own_lsu) && m_rvalid);
  assign lsu_rdata  = clint_pend_q ? clint_rd.rdata : m_rdata;
  assign lsu_rresp  = clint_pend_q ? clint_rd.rresp : m_rresp;

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      grant_q <= own_none;
    end else if (m_arvalid && m_arready) begin
      grant_q <= winner;
    end else if (m_rvalid && m_rready) begin
      grant_q <= own_none;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      ar_lock_q <= 1'b0;
      ar_sel_q  <= own_none;
    end else begin
      ar_lock_q <= m_arvalid && !m_arready;
      if (m_arvalid) ar_sel_q <= winner;
    end
  end

  always_ff @(posedge clock or negedge arst_n) begin
    if (!arst_n) begin
      clint_pend_q <= 1'b0;
    end else if (clint_rd.arvalid && clint_rd.arready) begin
      clint_pend_q <= 1'b1;
    end else if (clint_pend_q && lsu_rvalid && lsu_rready) begin
      clint_pend_q <= 1'b0;
    end
  end

  // write path, no latency
  assign m_awaddr    = lsu_awaddr;
  assign m_awsize    = lsu_awsize;
  assign m_awvalid   = lsu_awvalid;
  assign lsu_awready = m_awready;
  assign m_wdata     = lsu_wdata;
  assign m_wstrb     = lsu_wstrb;
  assign m_wvalid    = lsu_wvalid;
  assign lsu_wready  = m_wready;
  assign lsu_bresp   = m_bresp;
  assign lsu_bvalid  = m_bvalid;
  assign m_bready    = lsu_bready;

endmodule

/* logic/mem_subsys_top.sv */
module mem_subsys_top (
  input  logic                        clock,
  input  logic                        arst_n,

  input  logic [bus_pkg::addr_w-1:0] fetch_araddr,
  input  logic                        fetch_arvalid,
  output logic                        fetch_arready,
  input  logic                        fetch_rready,
  output logic [bus_pkg::data_w-1:0] fetch_rdata,
  output bus_pkg::resp_t              fetch_rresp,
  output logic                        fetch_rvalid,

  input  logic [bus_pkg::addr_w-1:0] lsu_araddr,
  input  logic [bus_pkg::size_w-1:0] lsu_arsize,
  input  logic                        lsu_arvalid,
  output logic                        lsu_arready,
  input  logic                        lsu_rready,
  output logic [bus_pkg::data_w-1:0] lsu_rdata,
  output bus_pkg::resp_t              lsu_rresp,
  output logic                        lsu_rvalid,

  input  logic [bus_pkg::addr_w-1:0] lsu_awaddr,
  input  logic [bus_pkg::size_w-1:0] lsu_awsize,
  input  logic                        lsu_awvalid,
  output logic                        lsu_awready,
  input  logic [bus_pkg::data_w-1:0] lsu_wdata,
  input  logic [bus_pkg::strb_w-1:0] lsu_wstrb,
  input  logic                        lsu_wvalid,
  output logic                        lsu_wready,
  input  logic                        lsu_bready,
  output bus_pkg::resp_t              lsu_bresp,
  output logic                        lsu_bvalid,

  output logic [bus_pkg::addr_w-1:0] m_araddr,
  output logic [bus_pkg::size_w-1:0] m_arsize,
  output logic                        m_arvalid,
  input  logic                        m_arready,
  input  logic [bus_pkg::data_w-1:0] m_rdata,
  input  bus_pkg::resp_t              m_rresp,
  input  logic                        m_rvalid,
  output logic                        m_rready,
  output logic [bus_pkg::addr_w-1:0] m_awaddr,
  output logic [bus_pkg::size_w-1:0] m_awsize,
  output logic                        m_awvalid,
  input  logic                        m_awready,
  output logic [bus_pkg::data_w-1:0] m_wdata,
  output logic [bus_pkg::strb_w-1:0] m_wstrb,
  output logic                        m_wvalid,
  input  logic                        m_wready,
  input  bus_pkg::resp_t              m_bresp,
  input  logic                        m_bvalid,
  output logic                        m_bready
);

  axi_rd_if lsu_clint_rd (); // port 1 reads of mtime

  // port names match the arbiter one to one
  bus_arbiter arb0 (
    .clint_rd (lsu_clint_rd.mst),
    .*
  );

  clint_timer clint0 (
    .clock  (clock),
    .arst_n (arst_n),
    .rd     (lsu_clint_rd.slv)
  );

endmodule

/* tests/bus_asserts.sv */
module bus_asserts (
  input logic                        clock,
  input logic                        arst_n,
  input logic                        fetch_rvalid,
  input logic                        fetch_rready,
  input logic                        lsu_rvalid,
  input logic                        lsu_rready,
  input logic [bus_pkg::addr_w-1:0] m_araddr,
  input logic                        m_arvalid,
  input logic                        m_arready,
  input logic                        clint_pend_q,
  input bus_pkg::grant_t             grant_q
);
  import bus_pkg::*;

  a_fetch_r_hold: assert property (@(posedge clock) disable iff (!arst_n)
    fetch_rvalid && !fetch_rready |=> fetch_rvalid) else $error("fetch_rvalid dropped");

  a_lsu_r_hold: assert property (@(posedge clock) disable iff (!arst_n)
    lsu_rvalid && !lsu_rready |=> lsu_rvalid) else $error("lsu_rvalid dropped");

  // address stays put while memory stalls
  a_m_ar_hold: assert property (@(posedge clock) disable iff (!arst_n)
    m_arvalid && !m_arready |=> m_arvalid && $stable(m_araddr))
    else $error("m_arvalid dropped or m_araddr changed");

  // one response source for port 1 at a time
  a_resp_sel: assert property (@(posedge clock) disable iff (!arst_n)
    !(clint_pend_q && grant_q == own_lsu)) else $error("grant and clint pending overlap");

  a_reset_ar: assert property (@(posedge clock)
    !arst_n |-> !m_arvalid) else $error("m_arvalid high in reset");

endmodule

bind bus_arbiter bus_asserts asrt0 (
  .clock        (clock),
  .arst_n       (arst_n),
  .fetch_rvalid (fetch_rvalid),
  .fetch_rready (fetch_rready),
  .lsu_rvalid   (lsu_rvalid),
  .lsu_rready   (lsu_rready),
  .m_araddr     (m_araddr),
  .m_arvalid    (m_arvalid),
  .m_arready    (m_arready),
  .clint_pend_q (clint_pend_q),
  .grant_q      (grant_q)
);

/* tests/tb_mem_subsys.sv */
module tb_mem_subsys;
  import bus_pkg::*;

  localparam int max_wait   = 100;
  localparam int run_cycles = 3000;

  logic clock;
  logic arst_n;
  logic [addr_w-1:0] fetch_araddr, lsu_araddr, lsu_awaddr, m_araddr, m_awaddr;
  logic [size_w-1:0] lsu_arsize, lsu_awsize, m_arsize, m_awsize;
  logic [data_w-1:0] fetch_rdata, lsu_rdata, lsu_wdata, m_rdata, m_wdata;
  logic [strb_w-1:0] lsu_wstrb, m_wstrb;
  resp_t fetch_rresp, lsu_rresp, lsu_bresp, m_rresp, m_bresp;
  logic fetch_arvalid, fetch_arready, fetch_rready, fetch_rvalid;
  logic lsu_arvalid, lsu_arready, lsu_rready, lsu_rvalid;
  logic lsu_awvalid, lsu_awready, lsu_wvalid, lsu_wready, lsu_bready, lsu_bvalid;
  logic m_arvalid, m_arready, m_rvalid, m_rready, m_awvalid, m_awready;
  logic m_wvalid, m_wready, m_bvalid, m_bready;

  logic [31:0] mem [16];     // external memory
  logic [31:0] ref_mem [16]; // reference copy
  logic [31:0] rnd, exp_fetch, exp_lsu, mr_data, last_mtime;
  logic [2:0]  lsu_kind;
  logic        mr_pend, mb_pend, prev_m_arvalid, timed_out;
  resp_t       mb_resp, exp_bresp;
  int fetch_st, lsu_st, fetch_wait, lsu_wait, cyc;
  int checks, errors, n_fetch, n_load, n_write, n_mtime, n_overlap;

  mem_subsys_top dut0 (.*);

  always #2 clock = ~clock;

  function automatic logic [31:0] xorshift(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] mem_addr(input logic [3:0] i);
    return 32'h8000_0000 | {26'd0, i, 2'b00};
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] data,
                                              input logic [3:0] strb);
    logic [31:0] res;
    res = old;
    for (int b = 0; b < 4; b++) begin
      if (strb[b]) res[8*b +: 8] = data[8*b +: 8];
    end
    return res;
  endfunction

  // top word of the window answers writes with slverr
  function automatic resp_t bresp_for(input logic [31:0] a);
    return (a[5:2] == 4'hf) ? resp_slverr : resp_okay;
  endfunction

  task automatic check_val(input string name, input logic [31:0] got, input logic [31:0] exp);
    checks++;
    assert (got === exp) else begin
      errors++;
      $display("Error %0t: %s got %h expected %h", $time, name, got, exp);
    end
  endtask

  task automatic check_cond(input logic ok, input string what);
    checks++;
    assert (ok) else begin
      errors++;
      $display("Failure at %0t: %s", $time, what);
    end
  endtask

  task drive_inputs();
    rnd = xorshift(rnd);
    m_arready = !mr_pend && rnd[0];
    m_rvalid  = mr_pend && (m_rvalid || rnd[1]);
    m_rdata   = mr_data;
    m_awready = !mb_pend && rnd[2];
    m_wready  = m_awready;
    m_bvalid  = mb_pend && (m_bvalid || rnd[3]);
    m_bresp   = mb_resp;
    fetch_rready = rnd[4];
    lsu_rready   = rnd[5];
    lsu_bready   = rnd[6];
    if (fetch_st == 0 && rnd[7]) begin
      fetch_araddr = mem_addr(rnd[19:16]);
      fetch_st = 1;
      fetch_wait = 0;
    end
    if (lsu_st == 0 && rnd[8]) begin
      lsu_kind = rnd[11:9];
      lsu_wait = 0;
      lsu_arsize = rnd[26] ? size_word : {2'b00, rnd[25]};
      lsu_awsize = rnd[28] ? size_word : {2'b00, rnd[27]};
      case (lsu_kind)
        3'd0, 3'd1, 3'd2: begin
          lsu_awaddr = mem_addr(rnd[23:20]);
          lsu_wdata  = xorshift(rnd ^ 32'h5a5a_0f0f);
          lsu_wstrb  = rnd[15:12];
          lsu_st = 3;
        end
        3'd5:    lsu_araddr = clint_mtime_lo;
        3'd6:    lsu_araddr = clint_mtime_hi;
        3'd7:    lsu_araddr = 32'h0200_0040; // next to the CLINT, external
        default: lsu_araddr = mem_addr(rnd[23:20]);
      endcase
      if (lsu_st == 0) lsu_st = 1;
    end
    fetch_arvalid = (fetch_st == 1);
    lsu_arvalid   = (lsu_st == 1);
    lsu_awvalid   = (lsu_st == 3);
    lsu_wvalid    = (lsu_st == 3);
  endtask

  // runs after inputs settle, so every handshake seen here lands on the next edge
  task observe();
    check_cond(!(fetch_rvalid && fetch_st != 2), "fetch_rvalid high with no fetch pending");
    check_cond(!(lsu_rvalid && lsu_st != 2), "lsu_rvalid high with no read pending");
    check_cond(!(lsu_bvalid && lsu_st != 4), "lsu_bvalid high with no write pending");
    check_cond(!(m_arvalid && (m_araddr == clint_mtime_lo || m_araddr == clint_mtime_hi)),
               "a CLINT read reached the external port");
    if (m_arvalid && !prev_m_arvalid && fetch_arvalid && lsu_arvalid)
      check_val("m_araddr", m_araddr, fetch_araddr);
    if (m_arvalid && m_arready) begin
      mr_pend = 1'b1;
      mr_data = mem[m_araddr[5:2]];
    end else if (m_rvalid && m_rready) begin
      mr_pend = 1'b0;
    end
    if (fetch_st == 1 && fetch_arready) begin
      check_val("m_araddr", m_araddr, fetch_araddr);
      check_val("m_arsize", 32'(m_arsize), 32'(size_word));
      exp_fetch = ref_mem[fetch_araddr[5:2]];
      fetch_st = 2;
    end else if (fetch_st == 2 && fetch_rvalid && fetch_rready) begin
      check_val("fetch_rdata", fetch_rdata, exp_fetch);
      check_val("fetch_rresp", 32'(fetch_rresp), 32'(resp_okay));
      if (lsu_st == 2 && (lsu_kind == 3'd5 || lsu_kind == 3'd6)) n_overlap++;
      fetch_st = 0;
      n_fetch++;
    end
    if (lsu_st == 1 && lsu_arready) begin
      if (lsu_kind != 3'd5 && lsu_kind != 3'd6) begin
        check_val("m_araddr", m_araddr, lsu_araddr);
        check_val("m_arsize", 32'(m_arsize), 32'(lsu_arsize));
      end
      exp_lsu = ref_mem[lsu_araddr[5:2]];
      lsu_st = 2;
    end else if (lsu_st == 2 && lsu_rvalid && lsu_rready) begin
      check_val("lsu_rresp", 32'(lsu_rresp), 32'(resp_okay));
      if (lsu_kind == 3'd5) begin
        check_cond(lsu_rdata > last_mtime, "mtime low word did not increase");
        last_mtime = lsu_rdata;
        n_mtime++;
      end else if (lsu_kind == 3'd6) begin
        check_val("lsu_rdata", lsu_rdata, 32'd0);
      end else begin
        check_val("lsu_rdata", lsu_rdata, exp_lsu);
        n_load++;
      end
      lsu_st = 0;
    end else if (lsu_st == 3 && lsu_awready && lsu_wready) begin
      check_val("m_awaddr", m_awaddr, lsu_awaddr);
      check_val("m_awsize", 32'(m_awsize), 32'(lsu_awsize));
      ref_mem[lsu_awaddr[5:2]] = merge_bytes(ref_mem[lsu_awaddr[5:2]], lsu_wdata, lsu_wstrb);
      exp_bresp = bresp_for(lsu_awaddr);
      lsu_st = 4;
    end else if (lsu_st == 4 && lsu_bvalid && lsu_bready) begin
      check_val("lsu_bresp", 32'(lsu_bresp), 32'(exp_bresp));
      lsu_st = 0;
      n_write++;
    end
    if (m_awvalid && m_awready && m_wvalid && m_wready) begin
      mem[m_awaddr[5:2]] = merge_bytes(mem[m_awaddr[5:2]], m_wdata, m_wstrb);
      mb_pend = 1'b1;
      mb_resp = bresp_for(m_awaddr);
    end else if (m_bvalid && m_bready) begin
      mb_pend = 1'b0;
    end
    if (fetch_st != 0) fetch_wait++;
    if (lsu_st != 0) lsu_wait++;
    if (fetch_wait > max_wait || lsu_wait > max_wait) begin
      $display("Timeout at %0t: a port waited more than %0d cycles", $time, max_wait);
      timed_out = 1'b1;
    end
    prev_m_arvalid = m_arvalid;
  endtask

  initial begin
    clock = 1'b0;
    arst_n = 1'b0;
    rnd = 32'd96;
    {fetch_araddr, fetch_arvalid, fetch_rready} = '0;
    {lsu_araddr, lsu_arvalid, lsu_rready, lsu_bready} = '0;
    {lsu_awaddr, lsu_awvalid, lsu_wdata, lsu_wstrb, lsu_wvalid} = '0;
    lsu_arsize = size_word;
    lsu_awsize = size_word;
    {m_arready, m_rdata, m_rvalid, m_awready, m_wready, m_bvalid} = '0;
    m_rresp = resp_okay;
    m_bresp = resp_okay;
    {mr_pend, mb_pend, prev_m_arvalid, timed_out} = '0;
    mr_data = '0;
    mb_resp = resp_okay;
    last_mtime = '0;
    lsu_kind = '0;
    {fetch_st, lsu_st, fetch_wait, lsu_wait} = '0;
    {checks, errors, n_fetch, n_load, n_write, n_mtime, n_overlap} = '0;
    for (int i = 0; i < 16; i++) begin
      mem[i] = 32'h8000_0000 + i * 32'h0004_0404 + 32'h1357_0000;
      ref_mem[i] = mem[i];
    end
    repeat (10) @(negedge clock);
    check_val("m_arvalid", 32'(m_arvalid), 0);
    check_val("m_awvalid", 32'(m_awvalid), 0);
    check_val("m_wvalid", 32'(m_wvalid), 0);
    check_val("m_bready", 32'(m_bready), 0);
    check_val("m_rready", 32'(m_rready), 0);
    check_val("fetch_rvalid", 32'(fetch_rvalid), 0);
    check_val("lsu_rvalid", 32'(lsu_rvalid), 0);
    check_val("lsu_bvalid", 32'(lsu_bvalid), 0);
    arst_n = 1'b1;
    for (cyc = 0; cyc < run_cycles && !timed_out; cyc++) begin
      @(negedge clock);
      drive_inputs();
      #1;
      observe();
    end
    check_cond(n_fetch > 0 && n_load > 0 && n_write > 0 && n_mtime > 1,
               "some transaction type never completed");
    check_cond(n_overlap > 0, "no fetch completed while an mtime read was pending");
    $display("Checks %0d, errors %0d, fetches %0d, loads %0d, writes %0d, mtime reads %0d, %s %0d",
             checks, errors, n_fetch, n_load, n_write, n_mtime,
             "fetches during mtime reads", n_overlap);
    if (errors == 0 && !timed_out) begin
      $display("Testbench passed");
    end else begin
      $display("Testbench failed");
    end
    $finish;
  end

endmodule

/* sim.f */
logic/bus_pkg.sv
logic/axi_rd_if.sv
logic/clint_timer.sv
logic/bus_arbiter.sv
logic/mem_subsys_top.sv
tests/bus_asserts.sv
tests/tb_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build with Verilator, run, and decide the result from the log.
cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  --top-module tb_mem_subsys \
  -f sim.f \
  -o tb_sim \
  && ./obj_dir/tb_sim > sim.log 2>&1 \
  && ! grep -q "Testbench failed" sim.log \
  && echo "simulation PASS" \
  || { echo "simulation FAIL, see sim.log"; exit 1; }
